//--- Makefile
# Verilator build and run for the LED strip testbench

VERILATOR ?= verilator
TOP       ?= tb_led_strip
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIMFLAGS  ?=

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(BIN)
	./$(BIN) $(SIMFLAGS)

clean:
	rm -rf $(OBJ_DIR)

//--- led_pkg.sv
package led_pkg;

    ////////////////////
    // Pixel word
    ////////////////////

    localparam int pixel_w = 24;

    // Wire order is green, red, blue
    typedef struct packed {
        logic [7:0] g;
        logic [7:0] r;
        logic [7:0] b;
    } pixel_ch_t;

    // Scaler reads channels, serializer reads the raw word
    typedef union packed {
        logic [pixel_w-1:0] raw;
        pixel_ch_t          ch;
    } pixel_u;

    // Serializer bit counter
    localparam int cnt_w = 5;

    // Pixel FIFO
    localparam int fifo_depth = 16;
    localparam int fifo_aw    = 4;

    ////////////////////
    // Line timing
    ////////////////////

    // Cycles per bit at 50 MHz, 1.26 us
    localparam int bit_cycles = 63;

    // High times for 0 and 1
    localparam int t0h_cycles = 20;
    localparam int t1h_cycles = 40;

    // Frame end gap, short for simulation
    localparam int latch_cycles = 300;

    // Period counter must hold the longest count
    localparam int per_w = $clog2(latch_cycles);

    ////////////////////
    // Encoder FSM
    ////////////////////

    typedef enum logic [1:0] {
        idle,
        bit_hi,
        bit_lo,
        latch
    } enc_state_e;

endpackage

//--- led_strip_top.sv
`timescale 1ns/1ps

module led_strip_top (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_pix_wr,
    input  led_pkg::pixel_u i_pix,
    input  logic [7:0]      i_brightness,
    output logic            o_fifo_full,
    output logic            o_busy,
    output logic            o_led_data
);

    led_pkg::pixel_u fifo_data;
    led_pkg::pixel_u staged_pix;

    logic fifo_empty;
    logic pop;
    logic staged;
    logic load;
    logic ser_bit;
    logic ser_bit_valid;
    logic shift;

    pixel_fifo u_fifo (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_wr    (i_pix_wr),
        .i_wdata (i_pix),
        .i_pop   (pop),
        .o_rdata (fifo_data),
        .o_empty (fifo_empty),
        .o_full  (o_fifo_full)
    );

    pixel_scaler u_scaler (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_fifo_empty (fifo_empty),
        .i_fifo_data  (fifo_data),
        .i_brightness (i_brightness),
        .i_load       (load),
        .o_pop        (pop),
        .o_staged     (staged),
        .o_pix        (staged_pix)
    );

    serializer u_serializer (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_staged    (staged),
        .i_word      (staged_pix),
        .i_shift     (shift),
        .o_load      (load),
        .o_bit       (ser_bit),
        .o_bit_valid (ser_bit_valid)
    );

    pulse_encoder u_encoder (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_bit       (ser_bit),
        .i_bit_valid (ser_bit_valid),
        .o_shift     (shift),
        .o_busy      (o_busy),
        .o_led       (o_led_data)
    );

endmodule

//--- pixel_fifo.sv
`timescale 1ns/1ps

module pixel_fifo (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_wr,
    input  led_pkg::pixel_u i_wdata,
    input  logic            i_pop,
    output led_pkg::pixel_u o_rdata,
    output logic            o_empty,
    output logic            o_full
);

    import led_pkg::*;

    pixel_u mem [fifo_depth];

    logic [fifo_aw-1:0] wr_ptr;
    logic [fifo_aw-1:0] rd_ptr;
    logic [fifo_aw:0]   count;

    logic do_wr;
    logic do_pop;

    // Drop writes when full and pops when empty
    assign do_wr  = i_wr && !o_full;
    assign do_pop = i_pop && !o_empty;

    assign o_empty = (count == '0);
    assign o_full  = (count == (fifo_aw + 1)'(fifo_depth));

    // Head entry, valid while not empty
    assign o_rdata = mem[rd_ptr];

    ////////////////////
    // Storage
    ////////////////////

    always_ff @(posedge i_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_wdata;
        end
    end

    ////////////////////
    // Pointers and count
    ////////////////////

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                // Depth is a power of two, pointers wrap
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({do_wr, do_pop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    // Both or neither keeps the count
                    count <= count;
                end
            endcase
        end
    end

endmodule

//--- pixel_scaler.sv
`timescale 1ns/1ps

module pixel_scaler (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_fifo_empty,
    input  led_pkg::pixel_u i_fifo_data,
    input  logic [7:0]      i_brightness,
    input  logic            i_load,
    output logic            o_pop,
    output logic            o_staged,
    output led_pkg::pixel_u o_pix
);

    // (c * (b + 1)) >> 8, so 255 passes c unchanged
    function automatic logic [7:0] scale(input logic [7:0] c, input logic [7:0] br);
        logic [16:0] prod;
        prod = c * ({1'b0, br} + 9'd1);
        return prod[15:8];
    endfunction

    // Pop only into an empty holding register
    assign o_pop = !o_staged && !i_fifo_empty;

    ////////////////////
    // Staged flag
    ////////////////////

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_staged <= 1'b0;
        end else if (o_pop) begin
            o_staged <= 1'b1;
        end else if (i_load) begin
            // Serializer took the pixel
            o_staged <= 1'b0;
        end
    end

    ////////////////////
    // Scaled pixel
    ////////////////////

    // Brightness is sampled together with the pop
    always_ff @(posedge i_clk) begin
        if (o_pop) begin
            o_pix.ch.g <= scale(i_fifo_data.ch.g, i_brightness);
            o_pix.ch.r <= scale(i_fifo_data.ch.r, i_brightness);
            o_pix.ch.b <= scale(i_fifo_data.ch.b, i_brightness);
        end
    end

endmodule

//--- pulse_encoder.sv
`timescale 1ns/1ps

module pulse_encoder (
    input  logic i_clk,
    input  logic i_rst,
    input  logic i_bit,
    input  logic i_bit_valid,
    output logic o_shift,
    output logic o_busy,
    output logic o_led
);

    import led_pkg::*;

    enc_state_e state;

    logic [per_w-1:0] per_cnt;
    logic [per_w-1:0] hi_last;

    logic period_end;
    logic latch_end;

    // Bit is held by the serializer for the whole period
    assign hi_last = i_bit ? per_w'(t1h_cycles - 1) : per_w'(t0h_cycles - 1);

    assign period_end = (per_cnt == per_w'(bit_cycles - 1));
    assign latch_end  = (per_cnt == per_w'(latch_cycles - 1));

    ////////////////////
    // Outputs
    ////////////////////

    // Line stays low if the period starts with no bit
    assign o_led = (state == bit_hi) && i_bit_valid;

    // One strobe on the last cycle of each period
    assign o_shift = (state == bit_lo) && period_end;

    assign o_busy = (state != idle) || i_bit_valid;

    ////////////////////
    // FSM
    ////////////////////

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state   <= idle;
            per_cnt <= '0;
        end else begin
            case (state)
                idle: begin
                    per_cnt <= '0;
                    if (i_bit_valid) begin
                        state <= bit_hi;
                    end
                end

                bit_hi: begin
                    if (!i_bit_valid) begin
                        // Frame done, start the gap
                        state   <= latch;
                        per_cnt <= '0;
                    end else begin
                        per_cnt <= per_cnt + 1'b1;
                        if (per_cnt == hi_last) begin
                            state <= bit_lo;
                        end
                    end
                end

                bit_lo: begin
                    if (period_end) begin
                        // Next bit is checked at the top of the period
                        state   <= bit_hi;
                        per_cnt <= '0;
                    end else begin
                        per_cnt <= per_cnt + 1'b1;
                    end
                end

                latch: begin
                    if (latch_end) begin
                        state   <= idle;
                        per_cnt <= '0;
                    end else begin
                        per_cnt <= per_cnt + 1'b1;
                    end
                end

                default: begin
                    state   <= idle;
                    per_cnt <= '0;
                end
            endcase
        end
    end

endmodule

//--- serializer.sv
`timescale 1ns/1ps

module serializer (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_staged,
    input  led_pkg::pixel_u i_word,
    input  logic            i_shift,
    output logic            o_load,
    output logic            o_bit,
    output logic            o_bit_valid
);

    import led_pkg::*;

    logic [pixel_w-1:0] shift_reg;
    logic [cnt_w-1:0]   bit_cnt;
    logic               busy;

    logic last_shift;
    logic ready;

    ////////////////////
    // Ready and load
    ////////////////////

    // 24th shift frees the register in the same cycle
    assign last_shift = i_shift && busy && (bit_cnt == cnt_w'(pixel_w - 1));

    // Ready is a level, no separate wait phase
    assign ready  = !busy || last_shift;
    assign o_load = ready && i_staged;

    // MSB first, g7 leads
    assign o_bit       = shift_reg[pixel_w-1];
    assign o_bit_valid = busy;

    ////////////////////
    // Control
    ////////////////////

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
        end else if (o_load) begin
            busy    <= 1'b1;
            bit_cnt <= '0;
        end else if (i_shift && busy) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (last_shift) begin
                busy <= 1'b0;
            end
        end
    end

    ////////////////////
    // Shift register
    ////////////////////

    always_ff @(posedge i_clk) begin
        if (o_load) begin
            shift_reg <= i_word.raw;
        end else if (i_shift && busy) begin
            shift_reg <= {shift_reg[pixel_w-2:0], 1'b0};
        end
    end

endmodule

//--- tb_led_strip.sv
`timescale 1ns/1ps

module tb_led_strip;

    import led_pkg::*;

    typedef struct packed {
        logic [2:0]               count;
        logic [7:0]               bright;
        logic [3:0][pixel_w-1:0]  pix;
        logic [3:0][pixel_w-1:0]  exp;
    } frame_row_t;

    logic       i_clk;
    logic       i_rst;
    logic       i_pix_wr;
    pixel_u     i_pix;
    logic [7:0] i_brightness;
    logic       o_fifo_full;
    logic       o_busy;
    logic       o_led_data;

    frame_row_t          rows [$];
    logic [pixel_w-1:0]  exp_q [$];
    logic [pixel_w-1:0]  words_q [$];
    logic [15:0]         lfsr;

    // Monitor state updated on falling edges
    logic               led_s = 1'b0;
    logic               busy_s = 1'b0;
    logic               full_s = 1'b0;
    logic               prev_led = 1'b0;
    logic               rise_seen = 1'b0;
    logic [pixel_w-1:0] shift_word = '0;
    int                 cyc = 0;
    int                 last_rise = 0;
    int                 high_run = 0;
    int                 low_run = 0;
    int                 bits_in_word = 0;

    led_strip_top UUT (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_pix_wr     (i_pix_wr),
        .i_pix        (i_pix),
        .i_brightness (i_brightness),
        .o_fifo_full  (o_fifo_full),
        .o_busy       (o_busy),
        .o_led_data   (o_led_data)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    ////////////////////
    // Reporting
    ////////////////////

    task automatic stop_run();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic fail_run(input string why);
        $display("ERROR at %0t ns: %s", $time, why);
        stop_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected == actual) else begin
            $display("CHECK FAILED at %0t ns: %s expected %0h got %0h",
                     $time, name, expected, actual);
            stop_run();
        end
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    function automatic logic [7:0] dim_channel(input logic [7:0] c, input logic [7:0] br);
        int v;
        v = (int'(c) * (int'(br) + 1)) / 256;
        return 8'(v);
    endfunction

    function automatic logic [pixel_w-1:0] expect_word(input logic [pixel_w-1:0] raw,
                                                       input logic [7:0] br);
        pixel_u in_pix;
        pixel_u out_pix;
        in_pix.raw   = raw;
        out_pix.ch.g = dim_channel(in_pix.ch.g, br);
        out_pix.ch.r = dim_channel(in_pix.ch.r, br);
        out_pix.ch.b = dim_channel(in_pix.ch.b, br);
        return out_pix.raw;
    endfunction

    // Galois form with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [pixel_w-1:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            v    = {v[pixel_w-2:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    ////////////////////
    // Stimulus table
    ////////////////////

    task automatic add_row(input int count, input logic [7:0] br,
                           input logic [3:0][pixel_w-1:0] pix);
        frame_row_t row;
        row.count  = 3'(count);
        row.bright = br;
        row.pix    = pix;
        for (int k = 0; k < 4; k++) begin
            row.exp[k] = expect_word(pix[k], br);
        end
        rows.push_back(row);
    endtask

    task automatic build_table();
        logic [pixel_w-1:0]       bits;
        int                       count;
        // Entry 0 is the rightmost pixel
        add_row(1, 8'd255, {24'h0, 24'h0, 24'h0, 24'hA53C0F});
        add_row(1, 8'd0,   {24'h0, 24'h0, 24'h0, 24'hFF8001});
        add_row(1, 8'd127, {24'h0, 24'h0, 24'h0, 24'hFF8001});
        add_row(1, 8'd200, {24'h0, 24'h0, 24'h0, 24'hC864FF});
        add_row(4, 8'd255, {24'hFEDCBA, 24'h123456, 24'h00FF00, 24'h800001});
        for (int r = 0; r < 3; r++) begin
            take_bits(2, bits);
            count = int'(bits[1:0]) + 1;
            take_bits(8, bits);
            add_row_random(count, bits[7:0]);
        end
    endtask

    task automatic add_row_random(input int count, input logic [7:0] br);
        logic [pixel_w-1:0]       bits;
        logic [3:0][pixel_w-1:0]  pix;
        pix = '0;
        for (int k = 0; k < count; k++) begin
            take_bits(pixel_w, bits);
            pix[k] = bits;
        end
        add_row(count, br, pix);
    endtask

    ////////////////////
    // Line monitor
    ////////////////////

    task automatic decode_bit();
        assert (high_run == t0h_cycles || high_run == t1h_cycles) else begin
            $display("CHECK FAILED at %0t ns: o_led_data high time expected %0d or %0d got %0d",
                     $time, t0h_cycles, t1h_cycles, high_run);
            stop_run();
        end
        // Long pulse reads as a one
        shift_word = {shift_word[pixel_w-2:0], high_run >= 30};
        bits_in_word++;
        if (bits_in_word == pixel_w) begin
            words_q.push_back(shift_word);
            bits_in_word = 0;
        end
    endtask

    always @(negedge i_clk) begin
        led_s  = o_led_data;
        busy_s = o_busy;
        full_s = o_fifo_full;
        cyc++;
        if (led_s) begin
            if (!prev_led) begin
                // Rising edges inside a frame are one period apart
                if (rise_seen && low_run < latch_cycles) begin
                    check_value("o_led_data bit period", bit_cycles, cyc - last_rise);
                end
                rise_seen = 1'b1;
                last_rise = cyc;
                high_run  = 0;
            end
            high_run++;
            low_run = 0;
            check_value("o_busy", 1, 32'(busy_s));
        end else begin
            if (prev_led) begin
                decode_bit();
            end
            low_run++;
        end
        prev_led = led_s;
    end

    ////////////////////
    // Frame checks
    ////////////////////

    task automatic check_quiet_outputs();
        check_value("o_led_data", 0, 32'(led_s));
        check_value("o_busy", 0, 32'(busy_s));
        check_value("o_fifo_full", 0, 32'(full_s));
    endtask

    task automatic wait_words(input int n);
        int limit;
        int waited;
        limit  = n * pixel_w * bit_cycles + 200;
        waited = 0;
        while (words_q.size() < n) begin
            if (waited >= limit) begin
                fail_run("timed out waiting for decoded LED words");
            end else begin
                @(posedge i_clk);
                waited++;
            end
        end
    endtask

    task automatic wait_idle();
        int limit;
        int waited;
        limit  = latch_cycles + 2 * bit_cycles + 20;
        waited = 0;
        while (busy_s) begin
            if (waited >= limit) begin
                fail_run("timed out waiting for o_busy to fall after the frame");
            end else begin
                @(posedge i_clk);
                waited++;
            end
        end
    endtask

    task automatic check_frame();
        int n;
        n = exp_q.size();
        wait_words(n);
        wait_idle();
        assert (low_run >= latch_cycles) else begin
            $display("CHECK FAILED at %0t ns: o_led_data low gap expected >= %0d got %0d",
                     $time, latch_cycles, low_run);
            stop_run();
        end
        check_value("partial word bits", 0, bits_in_word);
        check_value("decoded word count", n, words_q.size());
        for (int k = 0; k < n; k++) begin
            check_value("o_led_data word", 32'(exp_q[k]), 32'(words_q[k]));
        end
        words_q.delete();
        exp_q.delete();
    endtask

    task automatic run_row(input frame_row_t row);
        int n;
        n = int'(row.count);
        for (int k = 0; k < n; k++) begin
            @(posedge i_clk);
            i_pix_wr     <= 1'b1;
            i_pix        <= row.pix[k];
            i_brightness <= row.bright;
            exp_q.push_back(row.exp[k]);
        end
        @(posedge i_clk);
        i_pix_wr <= 1'b0;
        check_frame();
    endtask

    // Fill until full so that one write lands on the full FIFO
    task automatic run_full_test();
        logic [pixel_w-1:0] sent [$];
        logic [pixel_w-1:0] pix;
        logic               seen_full;
        seen_full = 1'b0;
        for (int k = 0; k < 40 && !seen_full; k++) begin
            @(posedge i_clk);
            if (full_s) begin
                seen_full = 1'b1;
                i_pix_wr  <= 1'b0;
            end else begin
                take_bits(pixel_w, pix);
                i_pix_wr     <= 1'b1;
                i_pix        <= pix;
                i_brightness <= 8'd255;
                sent.push_back(pix);
            end
        end
        if (!seen_full) begin
            fail_run("o_fifo_full never rose while writing pixels");
        end
        // Last write is dropped
        void'(sent.pop_back());
        // Full FIFO plus one staged word and one in the serializer
        check_value("accepted pixel count", fifo_depth + 2, sent.size());
        foreach (sent[k]) begin
            exp_q.push_back(expect_word(sent[k], 8'd255));
        end
        check_frame();
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        i_rst        <= 1'b1;
        i_pix_wr     <= 1'b0;
        i_pix        <= '0;
        i_brightness <= 8'd0;
        lfsr = 16'd2301;
        build_table();

        for (int k = 0; k < 3; k++) begin
            @(posedge i_clk);
            if (k != 0) begin
                check_quiet_outputs();
            end
        end
        i_rst <= 1'b0;

        // Idle line with an empty FIFO
        repeat (100) begin
            @(posedge i_clk);
            check_quiet_outputs();
        end

        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        run_full_test();

        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- vlog.f
led_pkg.sv
pixel_fifo.sv
pixel_scaler.sv
serializer.sv
pulse_encoder.sv
led_strip_top.sv
tb_led_strip.sv
